//--- rtl/shim_fault_encoder.sv
module shim_fault_encoder import shim_pkg::*; (
  input  cfg_faults_t   cfg_faults,
  input  boot_faults_t  boot_faults,
  input  run_faults_t   run_faults,
  output fault_report_t cfg_report,
  output fault_report_t boot_report,
  output fault_report_t run_report
);

  // Lowest set bit wins
  function automatic logic [BOARD_W-1:0] lowest_board(logic [NUM_BOARDS-1:0] flags);
    logic [BOARD_W-1:0] idx;
    idx = '0;
    for (int i = NUM_BOARDS - 1; i >= 0; i--) begin
      if (flags[i]) idx = BOARD_W'(i);
    end
    return idx;
  endfunction

  // Configuration out of bounds, no board number
  always_comb begin
    cfg_report       = '{valid: |cfg_faults, code: STS_OK, board: '0};
    if (cfg_faults.integ_thresh_avg_oob) cfg_report.code = STS_INTEG_THRESH_AVG_OOB;
    else if (cfg_faults.integ_window_oob) cfg_report.code = STS_INTEG_WINDOW_OOB;
    else if (cfg_faults.integ_en_oob)     cfg_report.code = STS_INTEG_EN_OOB;
    else if (cfg_faults.sys_en_oob)       cfg_report.code = STS_SYS_EN_OOB;
  end

  // DAC boot ranks before ADC boot
  always_comb begin
    boot_report = '{valid: |boot_faults, code: STS_OK, board: '0};
    if (|boot_faults.dac_boot_fail) begin
      boot_report.code  = STS_DAC_BOOT_FAIL;
      boot_report.board = lowest_board(boot_faults.dac_boot_fail);
    end else if (|boot_faults.adc_boot_fail) begin
      boot_report.code  = STS_ADC_BOOT_FAIL;
      boot_report.board = lowest_board(boot_faults.adc_boot_fail);
    end
  end

  // Running faults in struct field order
  always_comb begin
    run_report = '{valid: |run_faults, code: STS_OK, board: '0};
    if (run_faults.lock_viol) begin
      run_report.code = STS_LOCK_VIOL;
    end else if (|run_faults.shutdown_sense) begin
      run_report.code  = STS_SHUTDOWN_SENSE;
      run_report.board = lowest_board(run_faults.shutdown_sense);
    end else if (run_faults.ext_shutdown) begin
      run_report.code = STS_EXT_SHUTDOWN;
    end else if (|run_faults.over_thresh) begin
      run_report.code  = STS_OVER_THRESH;
      run_report.board = lowest_board(run_faults.over_thresh);
    end else if (run_faults.bad_trig_cmd) begin
      run_report.code = STS_BAD_TRIG_CMD;
    end else if (|run_faults.bad_dac_cmd) begin
      run_report.code  = STS_BAD_DAC_CMD;
      run_report.board = lowest_board(run_faults.bad_dac_cmd);
    end else if (|run_faults.bad_adc_cmd) begin
      run_report.code  = STS_BAD_ADC_CMD;
      run_report.board = lowest_board(run_faults.bad_adc_cmd);
    end
  end

endmodule

//--- rtl/shim_hw_manager.sv
module shim_hw_manager import shim_pkg::*; #(
  parameter int unsigned SPI_RESET_WAIT       = 25000000,  // 100 ms at 250 MHz
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25000000,  // 100 ms
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25000,     // 100 us
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25000000,  // 100 ms
  parameter int unsigned SPI_START_WAIT       = 250000000  // 1 s
) (
  input  logic         clk,
  input  logic         aresetn,
  input  logic         sys_en,
  input  logic         spi_off,
  input  cfg_faults_t  cfg_faults,
  input  boot_faults_t boot_faults,
  input  run_faults_t  run_faults,
  output pwr_ctrl_t    pwr_ctrl,
  output logic [31:0]  status_word,
  output logic         ps_interrupt
);

  logic          timer_restart;
  timer_sel_t    timer_sel;
  logic          elapsed, settled;
  fault_report_t cfg_report, boot_report, run_report;
  logic          record, clear, irq;
  fault_report_t report;
  state_t        state;

  shim_seq_fsm u_fsm (
    .clk, .aresetn, .sys_en, .spi_off, .elapsed, .settled,
    .cfg_report, .boot_report, .run_report,
    .timer_restart, .timer_sel, .state, .pwr_ctrl,
    .record, .clear, .irq, .report
  );

  shim_seq_timer #(
    .SPI_RESET_WAIT       (SPI_RESET_WAIT),
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) u_timer (
    .clk, .aresetn, .timer_restart, .timer_sel, .elapsed, .settled
  );

  // Pure combinational, zero latency
  shim_fault_encoder u_enc (
    .cfg_faults, .boot_faults, .run_faults, .cfg_report, .boot_report, .run_report
  );

  shim_status_log u_log (
    .clk, .aresetn, .record, .clear, .irq, .report, .state, .status_word, .ps_interrupt
  );

endmodule

//--- rtl/shim_pkg.sv
package shim_pkg;

  localparam int NUM_BOARDS   = 8;
  localparam int BOARD_W      = 3;  // Board number width
  localparam int CODE_W       = 25; // Status code width
  localparam int TIMER_W      = 32;
  localparam int SPI_MIN_WAIT = 10; // Settle cycles before spi_off is trusted

  // Sequencer states, encodings match the status word field
  typedef enum logic [3:0] {
    S_IDLE              = 4'd1,
    S_CONFIRM_SPI_RST   = 4'd2,
    S_POWER_ON_CTRL_BRD = 4'd3,
    S_CONFIRM_SPI_START = 4'd4,
    S_POWER_ON_AMP_BRD  = 4'd5,
    S_AMP_POWER_WAIT    = 4'd6,
    S_RUNNING           = 4'd7,
    S_HALTED            = 4'd8
  } state_t;

  // Basic system
  localparam logic [CODE_W-1:0] STS_EMPTY                = 25'h0000;
  localparam logic [CODE_W-1:0] STS_OK                   = 25'h0001;
  localparam logic [CODE_W-1:0] STS_PS_SHUTDOWN          = 25'h0002;
  // SPI subsystem
  localparam logic [CODE_W-1:0] STS_SPI_START_TIMEOUT    = 25'h0100;
  localparam logic [CODE_W-1:0] STS_SPI_RESET_TIMEOUT    = 25'h0101;
  // Configuration checks
  localparam logic [CODE_W-1:0] STS_INTEG_THRESH_AVG_OOB = 25'h0200;
  localparam logic [CODE_W-1:0] STS_INTEG_WINDOW_OOB     = 25'h0201;
  localparam logic [CODE_W-1:0] STS_INTEG_EN_OOB         = 25'h0202;
  localparam logic [CODE_W-1:0] STS_SYS_EN_OOB           = 25'h0203;
  localparam logic [CODE_W-1:0] STS_LOCK_VIOL            = 25'h0204;
  // Shutdown and integrator
  localparam logic [CODE_W-1:0] STS_SHUTDOWN_SENSE       = 25'h0300;
  localparam logic [CODE_W-1:0] STS_EXT_SHUTDOWN         = 25'h0301;
  localparam logic [CODE_W-1:0] STS_OVER_THRESH          = 25'h0400;
  // Trigger, DAC and ADC
  localparam logic [CODE_W-1:0] STS_BAD_TRIG_CMD         = 25'h0500;
  localparam logic [CODE_W-1:0] STS_DAC_BOOT_FAIL        = 25'h0600;
  localparam logic [CODE_W-1:0] STS_BAD_DAC_CMD          = 25'h0601;
  localparam logic [CODE_W-1:0] STS_ADC_BOOT_FAIL        = 25'h0700;
  localparam logic [CODE_W-1:0] STS_BAD_ADC_CMD          = 25'h0701;

  typedef struct packed {
    logic integ_thresh_avg_oob;
    logic integ_window_oob;
    logic integ_en_oob;
    logic sys_en_oob;
  } cfg_faults_t;

  typedef struct packed {
    logic [NUM_BOARDS-1:0] dac_boot_fail;
    logic [NUM_BOARDS-1:0] adc_boot_fail;
  } boot_faults_t;

  // Field order is priority order, highest first
  typedef struct packed {
    logic                  lock_viol;
    logic [NUM_BOARDS-1:0] shutdown_sense;
    logic                  ext_shutdown;
    logic [NUM_BOARDS-1:0] over_thresh;
    logic                  bad_trig_cmd;
    logic [NUM_BOARDS-1:0] bad_dac_cmd;
    logic [NUM_BOARDS-1:0] bad_adc_cmd;
  } run_faults_t;

  typedef struct packed {
    logic                valid;
    logic [CODE_W-1:0]   code;
    logic [BOARD_W-1:0]  board;
  } fault_report_t;

  typedef struct packed {
    logic unlock_cfg;
    logic spi_clk_power_n;   // Active low
    logic spi_en;
    logic shutdown_sense_en;
    logic block_buffers;
    logic n_shutdown_force;  // Active low
    logic n_shutdown_rst;    // Active low
  } pwr_ctrl_t;

  // Which delay the timer compares against
  typedef enum logic [2:0] {
    TSEL_SPI_RESET,
    TSEL_FORCE,
    TSEL_RST_PULSE,
    TSEL_RST_DELAY,
    TSEL_SPI_START
  } timer_sel_t;

endpackage

//--- rtl/shim_seq_fsm.sv
module shim_seq_fsm import shim_pkg::*; (
  input  logic          clk,
  input  logic          aresetn,
  input  logic          sys_en,
  input  logic          spi_off,
  input  logic          elapsed,
  input  logic          settled,
  input  fault_report_t cfg_report,
  input  fault_report_t boot_report,
  input  fault_report_t run_report,
  output logic          timer_restart,
  output timer_sel_t    timer_sel,
  output state_t        state,
  output pwr_ctrl_t     pwr_ctrl,
  output logic          record,
  output logic          clear,
  output logic          irq,
  output fault_report_t report
);

  // Everything safe: forced off, buffers blocked, config unlocked
  localparam pwr_ctrl_t CTRL_RESET = '{
    unlock_cfg:        1'b1,
    spi_clk_power_n:   1'b1,
    spi_en:            1'b0,
    shutdown_sense_en: 1'b0,
    block_buffers:     1'b1,
    n_shutdown_force:  1'b0,
    n_shutdown_rst:    1'b1
  };

  state_t     state_q, state_d;
  pwr_ctrl_t  ctrl_q, ctrl_d;
  timer_sel_t sel_q;
  logic       halt;

  // Plain status report without board number
  function automatic fault_report_t sts_report(logic [CODE_W-1:0] sts);
    return '{valid: 1'b1, code: sts, board: '0};
  endfunction

  // Halt set, config lock left as is
  function automatic pwr_ctrl_t halted(pwr_ctrl_t c);
    pwr_ctrl_t h;
    h                   = CTRL_RESET;
    h.unlock_cfg        = c.unlock_cfg;
    return h;
  endfunction

  // Delay used by each timed state
  function automatic timer_sel_t sel_for(state_t s);
    case (s)
      S_POWER_ON_CTRL_BRD: return TSEL_FORCE;
      S_CONFIRM_SPI_START: return TSEL_SPI_START;
      S_POWER_ON_AMP_BRD:  return TSEL_RST_PULSE;
      S_AMP_POWER_WAIT:    return TSEL_RST_DELAY;
      default:             return TSEL_SPI_RESET;
    endcase
  endfunction

  always_comb begin
    state_d = state_q;
    ctrl_d  = ctrl_q;
    halt    = 1'b0;
    clear   = 1'b0;
    report  = sts_report(STS_OK);
    case (state_q)
      S_IDLE: begin
        if (sys_en && cfg_report.valid) begin
          halt   = 1'b1;
          report = cfg_report;
        end else if (sys_en) begin
          state_d                = S_CONFIRM_SPI_RST;
          ctrl_d.unlock_cfg      = 1'b0; // Lock config
          ctrl_d.spi_clk_power_n = 1'b0; // SPI clock on
        end
      end
      S_CONFIRM_SPI_RST: begin
        if (settled && spi_off) begin
          state_d                 = S_POWER_ON_CTRL_BRD;
          ctrl_d.spi_clk_power_n  = 1'b1;
          ctrl_d.n_shutdown_force = 1'b1; // Release force
        end else if (elapsed) begin
          halt   = 1'b1;
          report = sts_report(STS_SPI_RESET_TIMEOUT);
        end
      end
      S_POWER_ON_CTRL_BRD: begin
        if (elapsed) begin
          state_d                  = S_CONFIRM_SPI_START;
          ctrl_d.shutdown_sense_en = 1'b1;
          ctrl_d.spi_clk_power_n   = 1'b0;
          ctrl_d.spi_en            = 1'b1;
        end
      end
      S_CONFIRM_SPI_START: begin
        if (!spi_off) begin
          state_d               = S_POWER_ON_AMP_BRD;
          ctrl_d.n_shutdown_rst = 1'b0; // Start of reset pulse
        end else if (boot_report.valid) begin
          halt   = 1'b1;
          report = boot_report;
        end else if (elapsed) begin
          halt   = 1'b1;
          report = sts_report(STS_SPI_START_TIMEOUT);
        end
      end
      S_POWER_ON_AMP_BRD: begin
        if (elapsed) begin
          state_d               = S_AMP_POWER_WAIT;
          ctrl_d.n_shutdown_rst = 1'b1;
        end
      end
      S_AMP_POWER_WAIT: begin
        if (elapsed) begin
          state_d              = S_RUNNING;
          ctrl_d.block_buffers = 1'b0;
        end
      end
      S_RUNNING: begin
        // Checked every cycle, sys_en drop first
        halt   = !sys_en || run_report.valid;
        report = !sys_en ? sts_report(STS_PS_SHUTDOWN) : run_report;
      end
      S_HALTED: begin
        if (!sys_en) begin
          state_d           = S_IDLE;
          clear             = 1'b1;
          ctrl_d.unlock_cfg = 1'b1;
        end
      end
      default: begin // Unused code, full safe set
        state_d = S_HALTED;
        ctrl_d  = CTRL_RESET;
        report  = sts_report(STS_EMPTY);
      end
    endcase
    if (halt) begin
      state_d = S_HALTED;
      ctrl_d  = halted(ctrl_q);
    end
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state_q <= S_IDLE;
      ctrl_q  <= CTRL_RESET;
      sel_q   <= TSEL_SPI_RESET;
    end else begin
      state_q <= state_d;
      ctrl_q  <= ctrl_d;
      sel_q   <= sel_for(state_d); // Ready with the new state
    end
  end

  // Strobes in the decision cycle, registered downstream
  assign timer_restart = (state_d != state_q);
  assign record        = timer_restart && (state_d == S_HALTED) && !clear;
  assign irq           = timer_restart && (state_d == S_RUNNING || state_d == S_HALTED);

  assign state     = state_q;
  assign pwr_ctrl  = ctrl_q;
  assign timer_sel = sel_q;

endmodule

//--- rtl/shim_seq_timer.sv
module shim_seq_timer import shim_pkg::*; #(
  parameter int unsigned SPI_RESET_WAIT       = 25000000,
  parameter int unsigned SHUTDOWN_FORCE_DELAY = 25000000,
  parameter int unsigned SHUTDOWN_RESET_PULSE = 25000,
  parameter int unsigned SHUTDOWN_RESET_DELAY = 25000000,
  parameter int unsigned SPI_START_WAIT       = 250000000
) (
  input  logic       clk,
  input  logic       aresetn,
  input  logic       timer_restart, // Taken in the cycle the FSM changes state
  input  timer_sel_t timer_sel,
  output logic       elapsed,
  output logic       settled
);

  logic [TIMER_W-1:0] count_q;
  logic [TIMER_W-1:0] delay;

  // Zero in the first cycle of the new state, then counts up and sticks at max
  always_ff @(posedge clk) begin
    if (!aresetn || timer_restart) begin
      count_q <= '0;
    end else if (count_q != '1) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    case (timer_sel)
      TSEL_FORCE:     delay = TIMER_W'(SHUTDOWN_FORCE_DELAY);
      TSEL_RST_PULSE: delay = TIMER_W'(SHUTDOWN_RESET_PULSE);
      TSEL_RST_DELAY: delay = TIMER_W'(SHUTDOWN_RESET_DELAY);
      TSEL_SPI_START: delay = TIMER_W'(SPI_START_WAIT);
      default:        delay = TIMER_W'(SPI_RESET_WAIT);
    endcase
  end

  assign elapsed = (count_q >= delay); // State lasts delay + 1 cycles
  assign settled = (count_q >= TIMER_W'(SPI_MIN_WAIT));

endmodule

//--- rtl/shim_status_log.sv
module shim_status_log import shim_pkg::*; (
  input  logic          clk,
  input  logic          aresetn,
  input  logic          record,  // Latch report code and board
  input  logic          clear,   // Back to STS_OK, board 0
  input  logic          irq,     // Entry to RUNNING or HALTED
  input  fault_report_t report,
  input  state_t        state,
  output logic [31:0]   status_word,
  output logic          ps_interrupt
);

  logic [CODE_W-1:0]  code_q;
  logic [BOARD_W-1:0] board_q;

  // Strobes arrive in the FSM decision cycle, so these land with the new state
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      code_q       <= STS_OK;
      board_q      <= '0;
      ps_interrupt <= 1'b0;
    end else begin
      ps_interrupt <= irq; // One cycle, first cycle of the new state
      if (clear) begin
        code_q  <= STS_OK;
        board_q <= '0;
      end else if (record && report.valid) begin
        code_q  <= report.code;
        board_q <= report.board;
      end
    end
  end

  // Board, code, state from the MSB down
  assign status_word = {board_q, code_q, state};

endmodule

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the shim_hw_manager testbench
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module shim_hw_manager_tb -f verilog.f -o sim_shim
if [ $? -ne 0 ]; then echo "Verilator build failed"; exit 1; fi

./obj_dir/sim_shim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then echo "Simulation exited with status $status"; exit 1; fi
if grep -q "Result: FAILED" "$LOG"; then exit 1; fi
if ! grep -q "Result: PASSED" "$LOG"; then echo "Simulation ended without a result"; exit 1; fi
exit 0

//--- verif/shim_hw_manager_properties.sv
module shim_hw_manager_properties import shim_pkg::*; (
  input logic        clk,
  input logic        aresetn,
  input pwr_ctrl_t   pwr_ctrl,
  input logic [31:0] status_word,
  input logic        ps_interrupt
);
  timeunit 1ns;
  timeprecision 1ps;

  // Interrupt is a single-cycle pulse
  irq_single_cycle: assert property (@(posedge clk) disable iff (!aresetn)
    ps_interrupt |=> !ps_interrupt)
    else $error("ps_interrupt stayed high for two cycles");

  // Buffers open only while running
  buffers_only_running: assert property (@(posedge clk) disable iff (!aresetn)
    !pwr_ctrl.block_buffers |-> (status_word[3:0] == S_RUNNING))
    else $error("block_buffers low outside RUNNING");

  rst_needs_force_off: assert property (@(posedge clk) disable iff (!aresetn)
    !pwr_ctrl.n_shutdown_rst |-> pwr_ctrl.n_shutdown_force)
    else $error("n_shutdown_rst low while shutdown is forced");

endmodule

bind shim_hw_manager shim_hw_manager_properties props_i (
  .clk          (clk),
  .aresetn      (aresetn),
  .pwr_ctrl     (pwr_ctrl),
  .status_word  (status_word),
  .ps_interrupt (ps_interrupt)
);

//--- verif/shim_hw_manager_tb.sv
module shim_hw_manager_tb import shim_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD           = 4;
  localparam int SPI_RESET_WAIT       = 40;
  localparam int SHUTDOWN_FORCE_DELAY = 20;
  localparam int SHUTDOWN_RESET_PULSE = 5;
  localparam int SHUTDOWN_RESET_DELAY = 20;
  localparam int SPI_START_WAIT       = 60;
  localparam int NUM_CFG_TESTS        = 8;
  localparam int NUM_BOOT_TESTS       = 8;
  localparam int NUM_RUN_TESTS        = 24;
  localparam int TEST_CYCLES          = 200; // Worst case of power-up plus halt plus recovery
  localparam int TIMEOUT_CYCLES       =
    8 + (3 + NUM_CFG_TESTS + NUM_BOOT_TESTS + NUM_RUN_TESTS) * TEST_CYCLES;
  localparam int RUN_W                = $bits(run_faults_t);

  logic         clk;
  logic         aresetn;
  logic         sys_en;
  logic         spi_off;
  cfg_faults_t  cfg_faults;
  boot_faults_t boot_faults;
  run_faults_t  run_faults;
  pwr_ctrl_t    pwr_ctrl;
  logic [31:0]  status_word;
  logic         ps_interrupt;

  string       exp_name_q[$]; // Pending status_word checks
  logic [31:0] exp_word_q[$];
  int          rst_low_cnt = 0;
  int          irq_cnt     = 0;

  shim_hw_manager #(
    .SPI_RESET_WAIT       (SPI_RESET_WAIT),
    .SHUTDOWN_FORCE_DELAY (SHUTDOWN_FORCE_DELAY),
    .SHUTDOWN_RESET_PULSE (SHUTDOWN_RESET_PULSE),
    .SHUTDOWN_RESET_DELAY (SHUTDOWN_RESET_DELAY),
    .SPI_START_WAIT       (SPI_START_WAIT)
  ) dut_i (
    .clk, .aresetn, .sys_en, .spi_off, .cfg_faults, .boot_faults, .run_faults,
    .pwr_ctrl, .status_word, .ps_interrupt
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Lowest board with its flag set
  function automatic logic [BOARD_W-1:0] first_set(logic [NUM_BOARDS-1:0] v);
    logic [BOARD_W-1:0] idx;
    logic               found;
    idx   = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_BOARDS; i++) begin
      if (v[i] && !found) begin
        idx   = BOARD_W'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  // Expected {board, code} by priority of config, boot, sys_en drop and running faults
  function automatic logic [BOARD_W+CODE_W-1:0] expected_fault(
    cfg_faults_t c, boot_faults_t b, run_faults_t r, logic en
  );
    logic [CODE_W-1:0]  code;
    logic [BOARD_W-1:0] board;
    logic [3:0]         cv;
    code  = STS_OK;
    board = '0;
    cv    = c;
    if (cv != '0) begin
      for (int i = 0; i < 4; i++) begin // MSB flag wins since codes count up from it
        if (cv[i]) code = STS_INTEG_THRESH_AVG_OOB + CODE_W'(3 - i);
      end
    end else if (b.dac_boot_fail != '0) begin
      code  = STS_DAC_BOOT_FAIL;
      board = first_set(b.dac_boot_fail);
    end else if (b.adc_boot_fail != '0) begin
      code  = STS_ADC_BOOT_FAIL;
      board = first_set(b.adc_boot_fail);
    end else if (!en) begin
      code = STS_PS_SHUTDOWN;
    end else if (r.lock_viol) begin
      code = STS_LOCK_VIOL;
    end else if (r.shutdown_sense != '0) begin
      code  = STS_SHUTDOWN_SENSE;
      board = first_set(r.shutdown_sense);
    end else if (r.ext_shutdown) begin
      code = STS_EXT_SHUTDOWN;
    end else if (r.over_thresh != '0) begin
      code  = STS_OVER_THRESH;
      board = first_set(r.over_thresh);
    end else if (r.bad_trig_cmd) begin
      code = STS_BAD_TRIG_CMD;
    end else if (r.bad_dac_cmd != '0) begin
      code  = STS_BAD_DAC_CMD;
      board = first_set(r.bad_dac_cmd);
    end else if (r.bad_adc_cmd != '0) begin
      code  = STS_BAD_ADC_CMD;
      board = first_set(r.bad_adc_cmd);
    end
    return {board, code};
  endfunction

  function automatic logic [31:0] status_of(logic [BOARD_W+CODE_W-1:0] fault, state_t s);
    return {fault, s};
  endfunction

  // Power controls after reset and in IDLE
  function automatic pwr_ctrl_t safe_ctrl();
    pwr_ctrl_t c;
    c.unlock_cfg        = 1'b1;
    c.spi_clk_power_n   = 1'b1;
    c.spi_en            = 1'b0;
    c.shutdown_sense_en = 1'b0;
    c.block_buffers     = 1'b1;
    c.n_shutdown_force  = 1'b0;
    c.n_shutdown_rst    = 1'b1;
    return c;
  endfunction

  // Power controls once RUNNING is reached
  function automatic pwr_ctrl_t running_ctrl();
    pwr_ctrl_t c;
    c.unlock_cfg        = 1'b0; // Config locked
    c.spi_clk_power_n   = 1'b0;
    c.spi_en            = 1'b1;
    c.shutdown_sense_en = 1'b1;
    c.block_buffers     = 1'b0;
    c.n_shutdown_force  = 1'b1;
    c.n_shutdown_rst    = 1'b1;
    return c;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1; // Drive point
  endtask

  task automatic wait_for_state(state_t s);
    while (status_word[3:0] != s) next_cycle();
  endtask

  // Waits for the state field to move and checks where it went
  task automatic step_to_state(string name, state_t exp);
    logic [3:0] prev;
    prev = status_word[3:0];
    while (status_word[3:0] == prev) next_cycle();
    check_value({name, " state"}, 32'(exp), 32'(status_word[3:0]));
  endtask

  // Hands a status_word check to the compare process and waits for it
  task automatic expect_status(string name, logic [31:0] word);
    exp_name_q.push_back(name);
    exp_word_q.push_back(word);
    wait (exp_word_q.size() == 0);
    next_cycle();
  endtask

  task automatic power_up(string name);
    spi_off = 1'b1; // SPI held in reset
    sys_en  = 1'b1;
    step_to_state(name, S_CONFIRM_SPI_RST);
    step_to_state(name, S_POWER_ON_CTRL_BRD);
    step_to_state(name, S_CONFIRM_SPI_START);
    spi_off = 1'b0; // Link up once the control board has power
    step_to_state(name, S_POWER_ON_AMP_BRD);
    step_to_state(name, S_AMP_POWER_WAIT);
    step_to_state(name, S_RUNNING);
    check_value({name, " irq"}, 32'd1, 32'(ps_interrupt)); // First RUNNING cycle
    expect_status(name, status_of({BOARD_W'(0), STS_OK}, S_RUNNING));
    check_value({name, " ctrl"}, 32'(running_ctrl()), 32'(pwr_ctrl));
  endtask

  // Halt code from the inputs currently held
  task automatic expect_halt(string name);
    wait_for_state(S_HALTED);
    check_value({name, " irq"}, 32'd1, 32'(ps_interrupt)); // First HALTED cycle
    expect_status(name, status_of(
      expected_fault(cfg_faults, boot_faults, run_faults, sys_en), S_HALTED));
    check_value({name, " block_buffers"}, 32'd1, 32'(pwr_ctrl.block_buffers));
  endtask

  task automatic recover(string name);
    sys_en      = 1'b0;
    cfg_faults  = '0;
    boot_faults = '0;
    run_faults  = '0;
    wait_for_state(S_IDLE);
    expect_status({name, " recovery"}, status_of({BOARD_W'(0), STS_OK}, S_IDLE));
    check_value({name, " recovery ctrl"}, 32'(safe_ctrl()), 32'(pwr_ctrl));
  endtask

  // Pulse length and interrupt counters
  always @(negedge clk) begin
    if (aresetn && !pwr_ctrl.n_shutdown_rst) rst_low_cnt++;
    if (aresetn && ps_interrupt) irq_cnt++;
  end

  initial begin : compare_proc
    forever begin
      @(negedge clk); // Mid-cycle when outputs are settled
      if (exp_word_q.size() != 0) begin
        check_value(exp_name_q.pop_front(), exp_word_q.pop_front(), status_word);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin : stimulus
    logic [RUN_W-1:0] bits;
    int               cycles;
    int               rst_base;
    int               irq_base;
    string            name;
    aresetn     = 1'b0;
    sys_en      = 1'b0;
    spi_off     = 1'b0;
    cfg_faults  = '0;
    boot_faults = '0;
    run_faults  = '0;
    void'($urandom(32'h24f264c6));
    repeat (8) @(posedge clk);
    #1;
    aresetn = 1'b1;
    next_cycle();

    expect_status("reset", status_of({BOARD_W'(0), STS_OK}, S_IDLE));
    check_value("reset ctrl", 32'(safe_ctrl()), 32'(pwr_ctrl));
    check_value("reset irq", 32'd0, 32'(ps_interrupt));

    // Normal power-up followed by shutdown through sys_en
    rst_base = rst_low_cnt;
    irq_base = irq_cnt;
    power_up("power_up");
    repeat (3) next_cycle();
    check_value("power_up rst pulse", 32'(SHUTDOWN_RESET_PULSE + 1),
                32'(rst_low_cnt - rst_base));
    check_value("power_up irq count", 32'd1, 32'(irq_cnt - irq_base));
    sys_en = 1'b0;
    expect_halt("power_up shutdown");
    recover("power_up");

    for (int n = 0; n < NUM_CFG_TESTS; n++) begin
      name       = $sformatf("cfg_fault_%0d", n);
      cfg_faults = cfg_faults_t'(4'($urandom_range(15, 1)));
      sys_en     = 1'b1;
      expect_halt(name);
      recover(name);
    end

    // spi_off never rises
    spi_off = 1'b0;
    sys_en  = 1'b1;
    wait_for_state(S_CONFIRM_SPI_RST);
    cycles = 0;
    while (status_word[3:0] == S_CONFIRM_SPI_RST) begin
      cycles++;
      next_cycle();
    end
    check_value("spi_reset_timeout cycles", 32'(SPI_RESET_WAIT + 1), 32'(cycles));
    check_value("spi_reset_timeout irq", 32'd1, 32'(ps_interrupt));
    expect_status("spi_reset_timeout",
                  status_of({BOARD_W'(0), STS_SPI_RESET_TIMEOUT}, S_HALTED));
    recover("spi_reset_timeout");

    for (int n = 0; n < NUM_BOOT_TESTS; n++) begin
      name        = $sformatf("boot_fault_%0d", n);
      boot_faults = boot_faults_t'(16'($urandom_range(65535, 1)));
      spi_off     = 1'b1; // Stays high so the boot check decides
      sys_en      = 1'b1;
      expect_halt(name);
      recover(name);
    end

    for (int n = 0; n < NUM_RUN_TESTS; n++) begin
      name = $sformatf("run_fault_%0d", n);
      power_up(name);
      repeat ($urandom_range(8, 2)) next_cycle(); // Well past the entry interrupt
      if ($urandom_range(3) == 0) begin
        sys_en = 1'b0;
      end else begin
        bits = '0;
        repeat ($urandom_range(3, 1)) begin
          bits = bits | (RUN_W'(1) << $urandom_range(RUN_W - 1));
        end
        run_faults = run_faults_t'(bits);
      end
      expect_halt(name);
      recover(name);
    end

    wait (exp_word_q.size() == 0);
    next_cycle();
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog.f
rtl/shim_pkg.sv
rtl/shim_seq_timer.sv
rtl/shim_fault_encoder.sv
rtl/shim_status_log.sv
rtl/shim_seq_fsm.sv
rtl/shim_hw_manager.sv
verif/shim_hw_manager_properties.sv
verif/shim_hw_manager_tb.sv
